/* host_settings.svh */
// ********************
// Widths and counts shared by the host domain package and RTL.
// Include this header wherever one of the macros is needed.
// ********************

`ifndef HOST_SETTINGS_SVH
`define HOST_SETTINGS_SVH

// APB byte address width
`define HOST_APB_AW 12

// APB data width, also the memory address width
`define HOST_APB_DW 32

// Four LLC events plus the cluster DMA event
`define HOST_NUM_EVENTS 5

// Flops in front of the DMA event edge detector
`define HOST_SYNC_STAGES 2

`endif

/* host_pkg.sv */
// ********************
// Types for the host domain: APB request and response, cache
// window, event strobes, counters and the register map.
// Modules take it with a wildcard import in their header.
// ********************

`include "host_settings.svh"

package host_pkg;

  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`HOST_APB_AW-1:0] paddr;
    logic [`HOST_APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`HOST_APB_DW-1:0] prdata;
    logic                    pready;
    logic                    pslverr;
  } apb_rsp_t;

  // Cacheable region, end address exclusive
  typedef struct packed {
    logic [`HOST_APB_DW-1:0] cache_start;
    logic [`HOST_APB_DW-1:0] cache_end;
  } llc_window_t;

  typedef struct packed {
    logic read_hit;
    logic read_miss;
    logic write_hit;
    logic write_miss;
  } llc_events_t;

  typedef logic [`HOST_NUM_EVENTS-1:0] event_vec_t;

  typedef logic [31:0] counter_t;

  // Bit positions inside event_vec_t
  localparam int unsigned EV_RD_HIT  = 0;
  localparam int unsigned EV_RD_MISS = 1;
  localparam int unsigned EV_WR_HIT  = 2;
  localparam int unsigned EV_WR_MISS = 3;
  localparam int unsigned EV_DMA     = 4;

  typedef enum logic [`HOST_APB_AW-1:0] {
    REG_CACHE_START = 12'h000,
    REG_CACHE_END   = 12'h004,
    REG_DOORBELL    = 12'h008,
    REG_CNT_RD_HIT  = 12'h010,
    REG_CNT_RD_MISS = 12'h014,
    REG_CNT_WR_HIT  = 12'h018,
    REG_CNT_WR_MISS = 12'h01C,
    REG_CNT_DMA     = 12'h020
  } reg_offset_e;

endpackage

/* host_apb_regs.sv */
// ********************
// APB register slave of the host domain. Every transfer takes one
// wait state. Holds the LLC window and the doorbell, reads back the
// event counters and clears a counter when its offset is written.
// ********************

`timescale 1ns/1ns

`include "host_settings.svh"

module host_apb_regs
  import host_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  apb_req_t                          apb_req_i,
  input  counter_t [`HOST_NUM_EVENTS-1:0]   counts_i,
  output apb_rsp_t                          apb_rsp_o,
  output llc_window_t                       window_o,
  output event_vec_t                        cnt_clear_o,
  output logic                              doorbell_irq_o
);

  logic                    access_first;
  logic                    wr_done;
  logic                    addr_hit;
  logic [`HOST_APB_DW-1:0] rdata;
  event_vec_t              clr_sel;

  logic                    pready_q;
  logic                    pslverr_q;
  logic [`HOST_APB_DW-1:0] prdata_q;
  llc_window_t             window_q;
  logic                    doorbell_q;

  // First access cycle samples the request, the second completes it
  assign access_first = apb_req_i.psel && apb_req_i.penable && !pready_q;
  assign wr_done      = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite && pready_q;

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    clr_sel  = '0;
    case (apb_req_i.paddr)
      REG_CACHE_START: rdata = window_q.cache_start;
      REG_CACHE_END:   rdata = window_q.cache_end;
      REG_DOORBELL:    rdata = {{(`HOST_APB_DW-1){1'b0}}, doorbell_q};
      REG_CNT_RD_HIT: begin
        rdata              = counts_i[EV_RD_HIT];
        clr_sel[EV_RD_HIT] = 1'b1;
      end
      REG_CNT_RD_MISS: begin
        rdata               = counts_i[EV_RD_MISS];
        clr_sel[EV_RD_MISS] = 1'b1;
      end
      REG_CNT_WR_HIT: begin
        rdata              = counts_i[EV_WR_HIT];
        clr_sel[EV_WR_HIT] = 1'b1;
      end
      REG_CNT_WR_MISS: begin
        rdata               = counts_i[EV_WR_MISS];
        clr_sel[EV_WR_MISS] = 1'b1;
      end
      REG_CNT_DMA: begin
        rdata           = counts_i[EV_DMA];
        clr_sel[EV_DMA] = 1'b1;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      pready_q  <= access_first;
      pslverr_q <= access_first && !addr_hit;
    end
  end

  // Only meaningful while pready is high
  always_ff @(posedge clk_i) begin
    if (access_first) begin
      prdata_q <= apb_req_i.pwrite ? '0 : rdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      window_q   <= '0;
      doorbell_q <= 1'b0;
    end else if (wr_done) begin
      case (apb_req_i.paddr)
        REG_CACHE_START: window_q.cache_start <= apb_req_i.pwdata;
        REG_CACHE_END:   window_q.cache_end   <= apb_req_i.pwdata;
        REG_DOORBELL:    doorbell_q           <= apb_req_i.pwdata[0];
        default: ;
      endcase
    end
  end

  // One-cycle clear, the cycle the write completes
  assign cnt_clear_o = wr_done ? clr_sel : '0;

  assign apb_rsp_o.prdata  = prdata_q;
  assign apb_rsp_o.pready  = pready_q;
  assign apb_rsp_o.pslverr = pslverr_q;
  assign window_o          = window_q;
  assign doorbell_irq_o    = doorbell_q;

  // Master must keep the access phase up across the wait state
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(pready_q) |-> apb_req_i.psel && apb_req_i.penable)
    else $error("pready raised outside an APB access phase");

endmodule

/* llc_access_monitor.sv */
// ********************
// Watches the memory access stream and raises one cache event per
// access inside the programmed window. Events are registered, so a
// strobe appears the cycle after the access was sampled.
// ********************

`timescale 1ns/1ns

`include "host_settings.svh"

module llc_access_monitor
  import host_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  llc_window_t             window_i,
  input  logic                    mem_valid_i,
  input  logic                    mem_write_i,
  input  logic                    mem_hit_i,
  input  logic [`HOST_APB_DW-1:0] mem_addr_i,
  output llc_events_t             events_o
);

  logic        in_window;
  llc_events_t events_d;
  llc_events_t events_q;

  // Start inclusive, end exclusive
  assign in_window = mem_valid_i &&
                     (mem_addr_i >= window_i.cache_start) &&
                     (mem_addr_i < window_i.cache_end);

  always_comb begin
    events_d            = '0;
    events_d.read_hit   = in_window && !mem_write_i && mem_hit_i;
    events_d.read_miss  = in_window && !mem_write_i && !mem_hit_i;
    events_d.write_hit  = in_window && mem_write_i && mem_hit_i;
    events_d.write_miss = in_window && mem_write_i && !mem_hit_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      events_q <= '0;
    end else begin
      events_q <= events_d;
    end
  end

  assign events_o = events_q;

  // At most one event per cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(events_o))
    else $error("LLC monitor raised more than one event");

endmodule

/* event_counter_bank.sv */
// ********************
// Bank of free-running event counters, one per event strobe.
// A clear in the same cycle as an increment wins, counts wrap.
// ********************

`timescale 1ns/1ns

`include "host_settings.svh"

module event_counter_bank
  import host_pkg::*;
#(
  parameter int unsigned NUM_EVENTS = `HOST_NUM_EVENTS
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  event_vec_t                 events_i,
  input  event_vec_t                 clear_i,
  output counter_t [NUM_EVENTS-1:0]  counts_o
);

  counter_t [NUM_EVENTS-1:0] count_q;

  // Event and clear vectors are indexed up to NUM_EVENTS
  if (NUM_EVENTS != $bits(event_vec_t)) begin : g_width_check
    $error("NUM_EVENTS does not match the event vector width");
  end

  for (genvar i = 0; i < NUM_EVENTS; i++) begin : g_cnt
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        count_q[i] <= '0;
      end else if (clear_i[i]) begin
        count_q[i] <= '0;
      end else if (events_i[i]) begin
        count_q[i] <= count_q[i] + 1'b1;
      end
    end
  end

  assign counts_o = count_q;

endmodule

/* dma_evt_edge_rx.sv */
// ********************
// Receiver for the cluster DMA event. The cluster toggles a level
// once per event. It is synchronized and returned as the ack, and
// each toggle yields one single-cycle pulse a cycle later.
// ********************

`timescale 1ns/1ns

`include "host_settings.svh"

module dma_evt_edge_rx (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  localparam int unsigned SYNC_MSB = `HOST_SYNC_STAGES - 1;

  logic [SYNC_MSB:0] sync_q;
  logic              last_q;
  logic              pulse_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q  <= '0;
      last_q  <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[SYNC_MSB-1:0], valid_i};
      last_q  <= sync_q[SYNC_MSB];
      // Toggle seen between the last two synchronized samples
      pulse_q <= sync_q[SYNC_MSB] ^ last_q;
    end
  end

  assign ack_o   = sync_q[SYNC_MSB];
  assign valid_o = pulse_q;

  // A pulse needs an ack transition in the cycle before it
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> ($past(ack_o) != $past(ack_o, 2)))
    else $error("DMA event pulse without an ack toggle");

endmodule

/* host_domain.sv */
// ********************
// Top of the host domain. Connects the APB register slave, the LLC
// access monitor, the DMA event receiver and the counter bank.
// Software programs the window and reads the counts over APB.
// ********************

`timescale 1ns/1ns

`include "host_settings.svh"

module host_domain
  import host_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  apb_req_t                apb_req_i,
  input  logic                    mem_valid_i,
  input  logic                    mem_write_i,
  input  logic                    mem_hit_i,
  input  logic [`HOST_APB_DW-1:0] mem_addr_i,
  input  logic                    dma_evt_valid_i,
  output apb_rsp_t                apb_rsp_o,
  output logic                    dma_evt_ack_o,
  output logic                    doorbell_irq_o
);

  llc_window_t                      llc_window;
  llc_events_t                      llc_events;
  logic                             dma_evt;
  event_vec_t                       events;
  event_vec_t                       cnt_clear;
  counter_t [`HOST_NUM_EVENTS-1:0]  counts;

  host_apb_regs i_apb_regs (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .apb_req_i      ( apb_req_i      ),
    .counts_i       ( counts         ),
    .apb_rsp_o      ( apb_rsp_o      ),
    .window_o       ( llc_window     ),
    .cnt_clear_o    ( cnt_clear      ),
    .doorbell_irq_o ( doorbell_irq_o )
  );

  llc_access_monitor i_llc_monitor (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .window_i    ( llc_window  ),
    .mem_valid_i ( mem_valid_i ),
    .mem_write_i ( mem_write_i ),
    .mem_hit_i   ( mem_hit_i   ),
    .mem_addr_i  ( mem_addr_i  ),
    .events_o    ( llc_events  )
  );

  dma_evt_edge_rx i_dma_evt_rx (
    .clk_i   ( clk_i           ),
    .reset_i ( reset_i         ),
    .valid_i ( dma_evt_valid_i ),
    .valid_o ( dma_evt         ),
    .ack_o   ( dma_evt_ack_o   )
  );

  // DMA on top, LLC events from bit 0 upward
  assign events = {dma_evt, llc_events.write_miss, llc_events.write_hit,
                   llc_events.read_miss, llc_events.read_hit};

  event_counter_bank #(
    .NUM_EVENTS ( `HOST_NUM_EVENTS )
  ) i_counters (
    .clk_i    ( clk_i     ),
    .reset_i  ( reset_i   ),
    .events_i ( events    ),
    .clear_i  ( cnt_clear ),
    .counts_o ( counts    )
  );

endmodule

/* tb_host_domain.sv */
// ********************
// Testbench for the host domain. Reads host_vectors.txt, drives APB,
// memory accesses and DMA event toggles on the falling edge, checks
// the responses and prints one line per test and a summary.
// ********************

`timescale 1ns/1ns

`include "host_settings.svh"

module tb_host_domain
  import host_pkg::*;
();

  localparam int TIMEOUT = 20;

  logic                    clk;
  logic                    reset;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  logic                    mem_valid;
  logic                    mem_write;
  logic                    mem_hit;
  logic [`HOST_APB_DW-1:0] mem_addr;
  logic                    dma_evt_valid;
  logic                    dma_evt_ack;
  logic                    doorbell_irq;

  integer                  seed;
  integer                  fd;
  integer                  code;
  integer                  count;
  logic [8*32-1:0]         op;
  logic [8*32-1:0]         name_tok;
  logic [8*128-1:0]        skip_line;
  logic [8*32-1:0]         test_names[$];
  logic [`HOST_APB_AW-1:0] offset;
  logic [`HOST_APB_DW-1:0] data;
  logic [`HOST_APB_DW-1:0] expd;
  logic                    flag_a;
  logic                    flag_b;
  int                      test_errs;
  int                      total_errs;
  int                      tests_run;
  int                      tests_failed;
  logic [`HOST_APB_DW-1:0] win_start;
  logic [`HOST_APB_DW-1:0] win_end;

  host_domain dut0 (
    .clk_i           ( clk           ),
    .reset_i         ( reset         ),
    .apb_req_i       ( apb_req       ),
    .mem_valid_i     ( mem_valid     ),
    .mem_write_i     ( mem_write     ),
    .mem_hit_i       ( mem_hit       ),
    .mem_addr_i      ( mem_addr      ),
    .dma_evt_valid_i ( dma_evt_valid ),
    .apb_rsp_o       ( apb_rsp       ),
    .dma_evt_ack_o   ( dma_evt_ack   ),
    .doorbell_irq_o  ( doorbell_irq  )
  );

  always #50 clk = ~clk;

  function automatic logic [8*32-1:0] current_test();
    if (tests_run < test_names.size()) begin
      return test_names[tests_run];
    end
    return "unnamed";
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch in test %0s: %0s expected 0x%08h actual 0x%08h",
               current_test(), what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic expect_fields(input integer got, input integer want);
    assert (got == want) else begin
      $display("Malformed %0s line in host_vectors.txt, expected %0d fields", op, want);
      test_errs++;
    end
  endtask

  // Setup cycle, access cycle, then hold until pready has been seen
  task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    int n;
    n = 0;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // First access cycle is the wait state
    assert (!apb_rsp.pready) else begin
      $display("APB transfer at offset 0x%03h raised pready without a wait state", addr);
      test_errs++;
    end
    @(negedge clk);
    while (!apb_rsp.pready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (apb_rsp.pready) else begin
      $display("APB transfer at offset 0x%03h got no pready within %0d cycles", addr, TIMEOUT);
      test_errs++;
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, wdata, rd, err);
    if (addr == REG_CACHE_START) win_start = wdata;
    if (addr == REG_CACHE_END) win_end = wdata;
  endtask

  task automatic read_reg(input logic [11:0] addr, input logic [31:0] expected,
                          input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, '0, rd, err);
    check_value($sformatf("read 0x%03h data", addr), expected, rd);
    check_value($sformatf("read 0x%03h pslverr", addr), {31'd0, exp_err}, {31'd0, err});
  endtask

  task automatic drive_access(input logic write, input logic hit, input logic [31:0] addr);
    @(negedge clk);
    mem_valid = 1'b1;
    mem_write = write;
    mem_hit   = hit;
    mem_addr  = addr;
    @(negedge clk);
    mem_valid = 1'b0;
  endtask

  task automatic toggle_dma();
    int n;
    n = 0;
    @(negedge clk);
    dma_evt_valid = ~dma_evt_valid;
    while (dma_evt_ack !== dma_evt_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (dma_evt_ack === dma_evt_valid) else begin
      $display("DMA event acknowledge did not follow the toggle within %0d cycles", TIMEOUT);
      test_errs++;
    end
  endtask

  task automatic check_outputs(input logic irq, input logic ack);
    @(negedge clk);
    check_value("doorbell_irq_o", {31'd0, irq}, {31'd0, doorbell_irq});
    check_value("dma_evt_ack_o", {31'd0, ack}, {31'd0, dma_evt_ack});
  endtask

  // Random addresses around the window, sorted by the window rule here
  task automatic random_accesses(input int num);
    logic [31:0] expected[4];
    logic [31:0] rd;
    logic [31:0] r;
    logic        err;
    int          idx;
    // Start from cleared LLC counters
    for (int i = 0; i < 4; i++) begin
      write_reg(12'h010 + {i[9:0], 2'b00}, '0);
      expected[i] = '0;
    end
    for (int k = 0; k < num; k++) begin
      r = $random(seed);
      @(negedge clk);
      mem_valid = 1'b1;
      mem_write = r[8];
      mem_hit   = r[9];
      mem_addr  = win_start - 32'h40 + {24'h0, r[7:0]};
      if (mem_addr >= win_start && mem_addr < win_end) begin
        idx = (r[8] ? 2 : 0) + (r[9] ? 0 : 1);
        expected[idx] = expected[idx] + 1;
      end
    end
    @(negedge clk);
    mem_valid = 1'b0;
    for (int i = 0; i < 4; i++) begin
      apb_xfer(1'b0, 12'h010 + {i[9:0], 2'b00}, '0, rd, err);
      check_value($sformatf("random count of event %0d", i), expected[i], rd);
    end
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("test %0s: passed", current_test());
    end else begin
      $display("test %0s: failed with %0d errors", current_test(), test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    test_errs = 0;
    tests_run++;
  endtask

  // First pass only picks up the test names for the error lines
  task automatic collect_test_names();
    fd = $fopen("host_vectors.txt", "r");
    while (fd != 0 && $fscanf(fd, "%s", op) == 1) begin
      if (op == "E") begin
        code = $fscanf(fd, "%s", name_tok);
        test_names.push_back(name_tok);
      end else begin
        code = $fgets(skip_line, fd);
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  initial begin
    seed          = 78;
    clk           = 1'b0;
    reset         = 1'b1;
    apb_req       = '0;
    mem_valid     = 1'b0;
    mem_write     = 1'b0;
    mem_hit       = 1'b0;
    mem_addr      = '0;
    dma_evt_valid = 1'b0;
    test_errs     = 0;
    total_errs    = 0;
    tests_run     = 0;
    tests_failed  = 0;
    win_start     = '0;
    win_end       = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    collect_test_names();
    fd = $fopen("host_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open host_vectors.txt for reading");
      total_errs++;
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op == "#") begin
          code = $fgets(skip_line, fd);
        end else if (op == "W") begin
          code = $fscanf(fd, "%h %h", offset, data);
          expect_fields(code, 2);
          write_reg(offset, data);
        end else if (op == "R") begin
          code = $fscanf(fd, "%h %h %h", offset, expd, flag_a);
          expect_fields(code, 3);
          read_reg(offset, expd, flag_a);
        end else if (op == "A") begin
          code = $fscanf(fd, "%h %h %h", flag_a, flag_b, data);
          expect_fields(code, 3);
          drive_access(flag_a, flag_b, data);
        end else if (op == "T") begin
          toggle_dma();
        end else if (op == "O") begin
          code = $fscanf(fd, "%h %h", flag_a, flag_b);
          expect_fields(code, 2);
          check_outputs(flag_a, flag_b);
        end else if (op == "N") begin
          code = $fscanf(fd, "%d", count);
          expect_fields(code, 1);
          random_accesses(count);
        end else if (op == "E") begin
          code = $fscanf(fd, "%s", name_tok);
          expect_fields(code, 1);
          finish_test();
        end else begin
          $display("Unknown opcode in host_vectors.txt");
          test_errs++;
        end
      end
      $fclose(fd);
    end
    total_errs += test_errs;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0 && tests_run > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* host_vectors.txt */
# Columns, hex: W off data | R off exp_data exp_pslverr | A write hit addr | O irq ack
# T toggles the DMA event | N count (decimal) random accesses | E test_name ends a test
R 000 00000000 0
R 004 00000000 0
R 008 00000000 0
R 010 00000000 0
R 014 00000000 0
R 018 00000000 0
R 01C 00000000 0
R 020 00000000 0
O 0 0
E reset_values
W 000 00001000
W 004 00001080
W 0C0 DEADBEEF
R 0C0 00000000 1
R 00C 00000000 1
R 000 00001000 0
R 004 00001080 0
E window_regs
A 0 1 00001000
A 0 0 0000107F
A 1 1 00001040
A 1 0 00001010
A 0 1 00000FFF
A 1 0 00001080
A 0 0 FFFFFFFF
R 010 00000001 0
R 014 00000001 0
R 018 00000001 0
R 01C 00000001 0
E llc_events
T
T
T
R 020 00000003 0
O 0 1
E dma_events
W 014 00000000
R 014 00000000 0
R 010 00000001 0
R 018 00000001 0
R 01C 00000001 0
R 020 00000003 0
E counter_clear
W 008 00000001
O 1 1
R 008 00000001 0
W 008 00000000
O 0 1
E doorbell
N 64
E random_window

/* host_domain.f */
+incdir+.
host_pkg.sv
host_apb_regs.sv
llc_access_monitor.sv
event_counter_bank.sv
dma_evt_edge_rx.sv
host_domain.sv
tb_host_domain.sv

/* run_sim.sh */
#!/bin/sh
# Builds the host domain testbench with Verilator and runs it.
# Exits non-zero if the build or the run fails or the pass line is missing.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f host_domain.f --top-module tb_host_domain
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_host_domain > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
